//--- rtl/ex_alu.sv
`timescale 1ns/1ps

module ex_alu
(
    input  ex_types_pkg::ds_to_es_t es_inst,
    output ex_types_pkg::word_t     alu_result
);
    import ex_types_pkg::*;

    word_t      alu_src1;
    word_t      alu_src2;
    logic [4:0] shamt;

    // pc relative ops take pc as source 1
    assign alu_src1 = es_inst.src1_is_pc  ? es_inst.pc  : es_inst.rj_value;
    assign alu_src2 = es_inst.src2_is_imm ? es_inst.imm : es_inst.rkd_value;
    assign shamt    = alu_src2[4:0];  // upper bits ignored

    always_comb
    begin
        case (es_inst.alu_op)
            alu_add:  alu_result = alu_src1 + alu_src2;  // also address calc
            alu_sub:  alu_result = alu_src1 - alu_src2;
            alu_slt:
            begin
                alu_result = {31'd0, $signed(alu_src1) < $signed(alu_src2)};
            end
            alu_sltu: alu_result = {31'd0, alu_src1 < alu_src2};
            alu_and:  alu_result = alu_src1 & alu_src2;
            alu_or:   alu_result = alu_src1 | alu_src2;
            alu_xor:  alu_result = alu_src1 ^ alu_src2;
            alu_nor:  alu_result = ~(alu_src1 | alu_src2);
            alu_sll:  alu_result = alu_src1 << shamt;
            alu_srl:  alu_result = alu_src1 >> shamt;
            alu_sra:
            begin
                alu_result = word_t'($signed(alu_src1) >>> shamt);  // sign fill
            end
            alu_lui:  alu_result = alu_src2;  // imm already shifted by decode
            default:  alu_result = '0;        // unused encodings
        endcase
    end

endmodule

//--- rtl/ex_lsu.sv
`timescale 1ns/1ps

module ex_lsu
(
    input  ex_types_pkg::ds_to_es_t  es_inst,
    input  logic                     es_valid,
    input  logic                     ms_allow_in,
    input  ex_types_pkg::word_t      alu_result,
    input  logic                     data_addr_ok,
    output logic                     data_req,
    output mem_access_pkg::data_req_t data_req_info,
    output logic                     mem_done,
    output logic                     ex_ale
);
    import ex_types_pkg::*;
    import mem_access_pkg::*;

    logic       is_load;
    logic       is_store;
    logic       is_mem;
    logic       word_acc;
    logic       half_acc;
    logic [1:0] offset;
    mem_size_t  size;
    byte_strb_t wstrb;
    word_t      wdata;

    assign offset   = alu_result[1:0];
    assign is_load  = (es_inst.ld_op != ld_none);
    assign is_store = (es_inst.st_op != st_none);
    assign is_mem   = is_load || is_store;

    assign word_acc = (es_inst.ld_op == ld_w) || (es_inst.st_op == st_w);
    assign half_acc = (es_inst.ld_op == ld_h) || (es_inst.ld_op == ld_hu)
                   || (es_inst.st_op == st_h);

    // byte accesses never fault
    assign ex_ale = es_valid && ((word_acc && (offset != 2'b00))
                              || (half_acc && offset[0]));

    always_comb
    begin
        if (word_acc)
            size = 2'd2;
        else if (half_acc)
            size = 2'd1;
        else
            size = 2'd0;  // byte, or no access at all
    end

    // lane enables, stores only
    always_comb
    begin
        case (es_inst.st_op)
            st_w:    wstrb = '1;
            st_b:    wstrb = byte_strb_t'(1) << offset;     // one hot lane
            st_h:    wstrb = offset[1] ? 4'b1100 : 4'b0011;
            default: wstrb = '0;
        endcase
    end

    // memory picks the lanes out by wstrb
    always_comb
    begin
        case (es_inst.st_op)
            st_w:    wdata = es_inst.rkd_value;
            st_b:    wdata = {BYTE_LANES{es_inst.rkd_value[7:0]}};
            st_h:    wdata = {2{es_inst.rkd_value[15:0]}};
            default: wdata = '0;
        endcase
    end

    // only ask while ms can take the instruction in the accept cycle
    assign data_req = es_valid && ms_allow_in && is_mem && !ex_ale;

    always_comb
    begin
        data_req_info.wr    = is_store;
        data_req_info.size  = size;
        data_req_info.wstrb = wstrb;
        data_req_info.addr  = {alu_result[31:2], 2'b00};  // word aligned
        data_req_info.wdata = wdata;
    end

    // faulting access goes down the pipe without touching memory
    assign mem_done = !is_mem || ex_ale || (data_req && data_addr_ok);

endmodule

//--- rtl/ex_pipe_ctrl.sv
`timescale 1ns/1ps

module ex_pipe_ctrl
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ds_to_es_valid,
    input  ex_types_pkg::ds_to_es_t ds_to_es_bus,
    input  logic                    ms_allow_in,
    input  ex_types_pkg::word_t     alu_result,
    input  logic                    mem_done,
    input  logic                    ex_ale,
    output logic                    es_allow_in,
    output logic                    es_to_ms_valid,
    output logic                    es_valid,
    output ex_types_pkg::ds_to_es_t es_inst,
    output ex_types_pkg::es_to_ms_t es_to_ms_bus,
    output ex_types_pkg::es_to_ds_t es_to_ds_bus
);
    import mem_access_pkg::*;

    logic es_ready_go;
    logic is_load;

    // done once the request is out, or at once for non memory ops
    assign es_ready_go = mem_done;

    // free slot, or the held one leaves this edge
    assign es_allow_in    = !es_valid || (es_ready_go && ms_allow_in);
    assign es_to_ms_valid = es_valid && es_ready_go;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            es_valid <= 1'b0;
        end
        else if (es_allow_in)
        begin
            es_valid <= ds_to_es_valid;  // bubble if decode has nothing
        end
    end

    // instruction payload, only loaded on a handshake
    always_ff @(posedge clk)
    begin
        if (ds_to_es_valid && es_allow_in)
        begin
            es_inst <= ds_to_es_bus;
        end
    end

    assign is_load = (es_inst.ld_op != ld_none);

    always_comb
    begin
        es_to_ms_bus.pc           = es_inst.pc;
        es_to_ms_bus.gr_we        = es_inst.gr_we && !ex_ale;  // faulting load writes nothing
        es_to_ms_bus.res_from_mem = is_load;
        es_to_ms_bus.dest         = es_inst.dest;
        es_to_ms_bus.result       = alu_result;
        es_to_ms_bus.byte_offset  = alu_result[1:0];  // lane select for load data
        es_to_ms_bus.ld_op        = es_inst.ld_op;
        es_to_ms_bus.ex_ale       = ex_ale;
    end

    // forwarding, decode qualifies with its own view of es valid
    always_comb
    begin
        es_to_ds_bus.gr_we   = es_inst.gr_we;
        es_to_ds_bus.dest    = es_inst.dest;
        es_to_ds_bus.is_load = is_load;     // load data only in ms
        es_to_ds_bus.result  = alu_result;
    end

endmodule

//--- rtl/ex_stage.sv
`timescale 1ns/1ps

module ex_stage
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ds_to_es_valid,
    input  ex_types_pkg::ds_to_es_t   ds_to_es_bus,
    output logic                      es_allow_in,
    input  logic                      ms_allow_in,
    output logic                      es_to_ms_valid,
    output ex_types_pkg::es_to_ms_t   es_to_ms_bus,
    output ex_types_pkg::es_to_ds_t   es_to_ds_bus,
    output logic                      data_req,
    output mem_access_pkg::data_req_t data_req_info,
    input  logic                      data_addr_ok
);
    import ex_types_pkg::*;

    ds_to_es_t es_inst;     // held instruction
    logic      es_valid;
    word_t     alu_result;
    logic      mem_done;    // ready go
    logic      ex_ale;

    ex_pipe_ctrl u_pipe_ctrl
    (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .ms_allow_in    (ms_allow_in),
        .alu_result     (alu_result),
        .mem_done       (mem_done),
        .ex_ale         (ex_ale),
        .es_allow_in    (es_allow_in),
        .es_to_ms_valid (es_to_ms_valid),
        .es_valid       (es_valid),
        .es_inst        (es_inst),
        .es_to_ms_bus   (es_to_ms_bus),
        .es_to_ds_bus   (es_to_ds_bus)
    );

    ex_alu u_alu
    (
        .es_inst    (es_inst),
        .alu_result (alu_result)
    );

    ex_lsu u_lsu
    (
        .es_inst       (es_inst),
        .es_valid      (es_valid),
        .ms_allow_in   (ms_allow_in),
        .alu_result    (alu_result),   // doubles as the access address
        .data_addr_ok  (data_addr_ok),
        .data_req      (data_req),
        .data_req_info (data_req_info),
        .mem_done      (mem_done),
        .ex_ale        (ex_ale)
    );

endmodule

//--- rtl/ex_types_pkg.sv
package ex_types_pkg;

    typedef logic [31:0] word_t;     // data or address
    typedef logic [4:0]  reg_idx_t;  // gpr index

    // alu operations, encoded, not one hot
    typedef enum logic [3:0]
    {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_nor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10,
        alu_lui  = 4'd11   // passes source 2 through
    } alu_op_t;

    // decode to execute
    typedef struct packed
    {
        word_t    pc;
        word_t    rj_value;
        word_t    rkd_value;    // also store data
        word_t    imm;
        reg_idx_t dest;
        logic     gr_we;
        logic     src1_is_pc;
        logic     src2_is_imm;
        alu_op_t  alu_op;
        mem_access_pkg::ld_op_t ld_op;
        mem_access_pkg::st_op_t st_op;
    } ds_to_es_t;

    // execute to memory stage
    typedef struct packed
    {
        word_t    pc;
        logic     gr_we;        // dropped when ale
        logic     res_from_mem;
        reg_idx_t dest;
        word_t    result;       // alu result or access address
        logic [1:0] byte_offset; // for load data extraction
        mem_access_pkg::ld_op_t ld_op;
        logic     ex_ale;
    } es_to_ms_t;

    // forwarding back to decode
    typedef struct packed
    {
        logic     gr_we;
        reg_idx_t dest;
        logic     is_load;      // value not ready yet, decode must stall
        word_t    result;
    } es_to_ds_t;

endpackage

//--- rtl/mem_access_pkg.sv
package mem_access_pkg;

    // data bus is one word wide
    localparam int BYTE_LANES = 4;

    // load kinds, ld_none marks a non-load
    typedef enum logic [2:0]
    {
        ld_none = 3'd0,
        ld_w    = 3'd1,
        ld_b    = 3'd2,   // sign extended in the memory stage
        ld_bu   = 3'd3,
        ld_h    = 3'd4,
        ld_hu   = 3'd5
    } ld_op_t;

    // store kinds
    typedef enum logic [1:0]
    {
        st_none = 2'd0,
        st_w    = 2'd1,
        st_b    = 2'd2,
        st_h    = 2'd3
    } st_op_t;

    // 0 byte, 1 half, 2 word
    typedef logic [1:0] mem_size_t;

    typedef logic [BYTE_LANES-1:0] byte_strb_t;   // one bit per byte lane

    // request payload toward data memory, req travels beside it
    typedef struct packed
    {
        logic       wr;     // 1 store, 0 load
        mem_size_t  size;
        byte_strb_t wstrb;  // zero for loads
        logic [31:0] addr;  // word aligned
        logic [31:0] wdata; // lanes already replicated
    } data_req_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# build the execute stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_ex_stage -f tb.f -o tb_ex_stage \
    && ./obj_dir/tb_ex_stage | tee /dev/stderr | grep -q "^TESTBENCH PASSED$" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

//--- tb.f
rtl/mem_access_pkg.sv
rtl/ex_types_pkg.sv
rtl/ex_pipe_ctrl.sv
rtl/ex_alu.sv
rtl/ex_lsu.sv
rtl/ex_stage.sv
tb/tb_ex_stage.sv

//--- tb/ex_input.txt
// pc rj rkd imm dest flags(gr_we,src1_is_pc,src2_is_imm) alu_op ld_op st_op
// expected: result ex_ale size wstrb wdata
1c000000 00001234 00000111 00000000 01 4 0 0 0 00001345 0 0 0 00000000
1c000004 00000010 00000020 00000000 02 4 1 0 0 fffffff0 0 0 0 00000000
1c000008 fffffffe 00000001 00000000 03 4 2 0 0 00000001 0 0 0 00000000
1c00000c fffffffe 00000001 00000000 04 4 3 0 0 00000000 0 0 0 00000000
1c000010 0f0f1234 deadbeef 00000ff0 05 5 4 0 0 00000230 0 0 0 00000000
1c000014 12340000 00000000 00000abc 06 5 5 0 0 12340abc 0 0 0 00000000
1c000018 ffff0000 0f0f0f0f 00000000 07 4 6 0 0 f0f00f0f 0 0 0 00000000
1c00001c 00ff00ff 0f000000 00000000 08 4 7 0 0 f000ff00 0 0 0 00000000
1c000020 00000003 00000000 00000024 09 5 8 0 0 00000030 0 0 0 00000000
1c000024 80000000 0000001f 00000000 0a 4 9 0 0 00000001 0 0 0 00000000
1c000028 80000000 00000000 00000004 0b 5 a 0 0 f8000000 0 0 0 00000000
1c00002c 00000000 00000000 12345000 0c 5 b 0 0 12345000 0 0 0 00000000
1c000030 00000000 00000000 00012000 0d 7 0 0 0 1c012030 0 0 0 00000000
1c000034 00008000 a1b2c3d4 00000010 00 1 0 0 1 00008010 0 2 f a1b2c3d4
1c000038 00008000 a1b2c3d4 00000011 00 1 0 0 1 00008011 1 2 f a1b2c3d4
1c00003c 00008000 a1b2c3d4 00000012 00 1 0 0 1 00008012 1 2 f a1b2c3d4
1c000040 00008000 a1b2c3d4 00000013 00 1 0 0 1 00008013 1 2 f a1b2c3d4
1c000044 00008000 a1b2c3d4 00000020 00 1 0 0 3 00008020 0 1 3 c3d4c3d4
1c000048 00008000 a1b2c3d4 00000021 00 1 0 0 3 00008021 1 1 3 c3d4c3d4
1c00004c 00008000 a1b2c3d4 00000022 00 1 0 0 3 00008022 0 1 c c3d4c3d4
1c000050 00008000 a1b2c3d4 00000023 00 1 0 0 3 00008023 1 1 c c3d4c3d4
1c000054 00008000 a1b2c3d4 00000030 00 1 0 0 2 00008030 0 0 1 d4d4d4d4
1c000058 00008000 a1b2c3d4 00000031 00 1 0 0 2 00008031 0 0 2 d4d4d4d4
1c00005c 00008000 a1b2c3d4 00000032 00 1 0 0 2 00008032 0 0 4 d4d4d4d4
1c000060 00008000 a1b2c3d4 00000033 00 1 0 0 2 00008033 0 0 8 d4d4d4d4
1c000064 00008050 00000000 fffffff0 10 5 0 1 0 00008040 0 2 0 00000000
1c000068 00008000 00000000 00000042 11 5 0 1 0 00008042 1 2 0 00000000
1c00006c 00008000 00000000 00000051 12 5 0 4 0 00008051 1 1 0 00000000
1c000070 00008000 00000000 00000052 13 5 0 4 0 00008052 0 1 0 00000000
1c000074 00008000 00000000 00000060 14 5 0 5 0 00008060 0 1 0 00000000
1c000078 00008000 00000000 00000063 15 5 0 5 0 00008063 1 1 0 00000000
1c00007c 00008000 00000000 00000071 16 5 0 2 0 00008071 0 0 0 00000000
1c000080 00008000 00000000 00000073 17 5 0 3 0 00008073 0 0 0 00000000

//--- tb/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;
    import ex_types_pkg::*;
    import mem_access_pkg::*;

    localparam int NUM_INST       = 33;                  // data lines in tb/ex_input.txt
    localparam int COLS           = 14;                  // hex words per line
    localparam int TIMEOUT_CYCLES = 20 * NUM_INST + 50;

    logic        clk            = 1'b0;
    logic        reset          = 1'b1;
    logic        ds_to_es_valid = 1'b0;
    ds_to_es_t   ds_to_es_bus   = '0;
    logic        es_allow_in;
    logic        ms_allow_in    = 1'b1;
    logic        es_to_ms_valid;
    es_to_ms_t   es_to_ms_bus;
    es_to_ds_t   es_to_ds_bus;
    logic        data_req;
    data_req_t   data_req_info;
    logic        data_addr_ok   = 1'b0;

    logic [31:0] vec_mem [0:NUM_INST*COLS-1];
    logic [31:0] rng_state = 32'h1095_d860;
    logic [1:0]  ok_wait   = 2'd0;   // req cycles left before addr_ok
    int          send_idx  = 0;
    int          recv_idx  = 0;      // next expected departure
    int          cycle_cnt = 0;
    logic        go        = 1'b0;   // driver enable

    ex_stage u_ex_stage
    (
        .clk            (clk),
        .reset          (reset),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_allow_in    (es_allow_in),
        .ms_allow_in    (ms_allow_in),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .es_to_ds_bus   (es_to_ds_bus),
        .data_req       (data_req),
        .data_req_info  (data_req_info),
        .data_addr_ok   (data_addr_ok)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // one data line into the decode bus
    function automatic ds_to_es_t build_inst(input int idx);
        ds_to_es_t inst;
        int        b;
        b                = idx * COLS;
        inst.pc          = vec_mem[b];
        inst.rj_value    = vec_mem[b+1];
        inst.rkd_value   = vec_mem[b+2];
        inst.imm         = vec_mem[b+3];
        inst.dest        = vec_mem[b+4][4:0];
        inst.gr_we       = vec_mem[b+5][2];
        inst.src1_is_pc  = vec_mem[b+5][1];
        inst.src2_is_imm = vec_mem[b+5][0];
        inst.alu_op      = alu_op_t'(vec_mem[b+6][3:0]);
        inst.ld_op       = ld_op_t'(vec_mem[b+7][2:0]);
        inst.st_op       = st_op_t'(vec_mem[b+8][1:0]);
        return inst;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic enforce_rule(input logic ok, input string what);
        assert (ok)
        else
        begin
            $display("%s (at %0t ns)", what, $time);
            $display("TESTBENCH FAILED");
            $fatal(1, "protocol violation");
        end
    endtask

    // instruction leaving on the coming edge
    task automatic inspect_departure(input int idx);
        int          b;
        logic        ale;
        logic        is_ld;
        logic        is_mem;
        logic [31:0] res;
        b      = idx * COLS;
        res    = vec_mem[b+9];
        ale    = vec_mem[b+10][0];
        is_ld  = (vec_mem[b+7] != 32'd0);
        is_mem = is_ld || (vec_mem[b+8] != 32'd0);
        compare_value("pc (order)", es_to_ms_bus.pc, vec_mem[b]);
        compare_value("result", es_to_ms_bus.result, res);
        compare_value("dest", 32'(es_to_ms_bus.dest), vec_mem[b+4]);
        compare_value("forwarded result", es_to_ds_bus.result, res);
        compare_value("forwarded dest", 32'(es_to_ds_bus.dest), vec_mem[b+4]);
        compare_value("forwarded gr_we", 32'(es_to_ds_bus.gr_we), 32'(vec_mem[b+5][2]));
        compare_value("forwarded is_load", 32'(es_to_ds_bus.is_load), 32'(is_ld));
        compare_value("ex_ale", 32'(es_to_ms_bus.ex_ale), 32'(ale));
        compare_value("gr_we", 32'(es_to_ms_bus.gr_we), 32'(vec_mem[b+5][2] && !ale));
        compare_value("res_from_mem", 32'(es_to_ms_bus.res_from_mem), 32'(is_ld));
        compare_value("ld_op", 32'(es_to_ms_bus.ld_op), vec_mem[b+7]);
        compare_value("byte_offset", 32'(es_to_ms_bus.byte_offset), 32'(res[1:0]));
        if (is_mem && !ale)
        begin
            enforce_rule(data_req && data_addr_ok, "memory op left without an accepted request");
            compare_value("wr", 32'(data_req_info.wr), 32'(vec_mem[b+8] != 32'd0));
            compare_value("size", 32'(data_req_info.size), vec_mem[b+11]);
            compare_value("wstrb", 32'(data_req_info.wstrb), vec_mem[b+12]);
            compare_value("wdata", data_req_info.wdata, vec_mem[b+13]);
            compare_value("addr", data_req_info.addr, res & 32'hffff_fffc);  // word aligned
        end
        else
        begin
            enforce_rule(!data_req, "data_req raised for a non-memory or misaligned op");
        end
    endtask

    // decode model, back to back offers
    always @(posedge clk)
    begin
        if (reset || !go)
        begin
            ds_to_es_valid <= 1'b0;
        end
        else if (!ds_to_es_valid || es_allow_in)
        begin
            if (send_idx < NUM_INST)
            begin
                ds_to_es_valid <= 1'b1;
                ds_to_es_bus   <= build_inst(send_idx);
                send_idx       <= send_idx + 1;
            end
            else
            begin
                ds_to_es_valid <= 1'b0;
            end
        end
    end

    // memory stage and data memory models, one random stream
    always @(posedge clk)
    begin
        rng_state = lcg_next(rng_state);
        ms_allow_in <= (rng_state[31:30] != 2'b00);  // stalls about a quarter of cycles
        if (data_req && data_addr_ok)
        begin
            data_addr_ok <= (rng_state[29:28] == 2'd0);  // 0 to 3 cycles for the next one
            ok_wait      <= rng_state[29:28] - 2'd1;
        end
        else if (data_req)
        begin
            if (ok_wait == 2'd0)
                data_addr_ok <= 1'b1;
            else
                ok_wait <= ok_wait - 2'd1;
        end
    end

    // sample mid cycle, everything settled
    always @(negedge clk)
    begin
        if (!reset)
        begin
            enforce_rule(!(data_req && !ms_allow_in), "data_req high while ms_allow_in low");
            if (data_req && data_addr_ok)
                enforce_rule(es_to_ms_valid && ms_allow_in, "request accepted but op held");
            if (es_to_ms_valid && ms_allow_in)
            begin
                enforce_rule(recv_idx < NUM_INST, "extra instruction left the stage");
                inspect_departure(recv_idx);
                recv_idx = recv_idx + 1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("pipeline stalled, %0d of %0d instructions left the stage", recv_idx,
                     NUM_INST);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        $readmemh("tb/ex_input.txt", vec_mem);
        enforce_rule(!$isunknown(vec_mem[NUM_INST*COLS-1]), "stimulus file missing or short");
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        // idle stage, nothing offered yet
        compare_value("es_allow_in after reset", 32'(es_allow_in), 32'd1);
        compare_value("es_to_ms_valid after reset", 32'(es_to_ms_valid), 32'd0);
        compare_value("data_req after reset", 32'(data_req), 32'd0);
        go = 1'b1;
        wait (recv_idx == NUM_INST);
        @(posedge clk);
        @(negedge clk);
        if (!es_to_ms_valid && !data_req && es_allow_in)
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
        else
        begin
            $display("stage not idle after the last instruction left");
            $display("TESTBENCH FAILED");
            $fatal(1, "end state wrong");
        end
    end

endmodule
